/* Bender.yml */
package:
  name: asg

sources:
  - common/asg_stream_pkg.sv
  - common/asg_cfg_pkg.sv
  - asg_channel/asg_table.sv
  - asg_channel/asg_channel.sv
  - rtl/stream_reg.sv
  - rtl/asg_mixer.sv
  - rtl/asg_top.sv
  - target: test
    files:
      - testbench/asg_tb.sv

/* asg_channel/asg_channel.sv */
`timescale 1ns/1ps

// one generator channel
// trigger and burst FSM, modulo phase pointer, sample stream out

module asg_channel import asg_cfg_pkg::*, asg_stream_pkg::*; (
  input  logic           sto,
  input  logic           ctl_rst,
  // table write
  input  logic           wen,
  input  logic [CWM-1:0] waddr,
  input  smp_dat_t       wdata,
  // control
  input  logic           trg,
  input  chn_cfg_t       cfg,
  // sample stream
  input  logic           smp_ready,
  output logic           smp_valid,
  output chn_smp_t       smp,
  // events and status
  output chn_evn_t       evn,
  output logic [CWL-1:0] sts_bln,
  output logic [CWN-1:0] sts_bnm
);

  // pointers
  logic [CWP-1:0] ptr_cur;
  logic [CWP:0]   ptr_nxt;
  logic [CWP:0]   ptr_mod;
  logic [CWP+1:0] ptr_sub;
  // table read side
  logic [CWM-1:0] raddr;
  smp_dat_t       rdata;
  // counter ends
  logic           end_bdl;
  logic           end_bln;
  logic           end_bnm;
  // FSM and pipeline state
  logic           sts_run;
  logic           sts_aen;
  logic           sts_ren;
  logic           sts_vld;
  logic           sts_lst;
  logic           sts_rpt;
  logic           sts_trg;
  logic           sts_rdy;
  logic           out_lst;

  ////////////////////////////////////////////////////////////
  // table
  ////////////////////////////////////////////////////////////

  asg_table #(.dt(smp_dat_t)) u_tbl (
    .sto   (sto),
    .wen   (wen),
    .waddr (waddr),
    .wdata (wdata),
    .ren   (sts_ren & sts_rdy),
    .raddr (raddr),
    .rdata (rdata)
  );

  // address stage
  always_ff @(posedge sto) begin
    if (sts_rdy && sts_aen) begin
      raddr <= ptr_cur[CWF+:CWM];
    end
  end

  // everything advances only when the output can move
  assign sts_rdy = smp_ready | ~smp_valid;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  // counter end checks
  assign end_bnm = (sts_bnm == cfg.bnm) & ~cfg.inf;
  assign end_bln = (sts_bln == cfg.bln);
  assign end_bdl = (sts_bln == cfg.bdl);

  // period restart in burst mode
  assign sts_rpt = sts_run & end_bln & cfg.ben;
  // outside pulse only counts while idle
  assign sts_trg = sts_run ? sts_rpt : trg;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_aen <= 1'b0;
      sts_run <= 1'b0;
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (sts_rdy) begin
      if (cfg.ben) begin
        if (sts_trg) begin
          // start, or next period, or stop after the final one
          sts_aen <= sts_run ? ~end_bnm : 1'b1;
          sts_run <= sts_run ? ~end_bnm : 1'b1;
          sts_bnm <= sts_run ? sts_bnm + CWN'(!cfg.inf) : '0;
          sts_bln <= '0;
        end else begin
          // data part over, repeat last value
          if (end_bdl) begin
            sts_aen <= 1'b0;
          end
          if (sts_run) begin
            sts_bln <= sts_bln + 1'b1;
          end
        end
      end else if (sts_trg) begin
        // periodic mode runs until reset
        sts_aen <= 1'b1;
        sts_run <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // modulo phase pointer
  ////////////////////////////////////////////////////////////

  // modulus is (siz+1) entries in fixed point
  assign ptr_mod = {(CWM+1)'(cfg.siz) + (CWM+1)'(1), {CWF{1'b0}}};
  assign ptr_nxt = {1'b0, ptr_cur} + {1'b0, cfg.ste} + (CWP+1)'(1);
  // sign bit set means no wrap
  assign ptr_sub = {1'b0, ptr_nxt} - {1'b0, ptr_mod};

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr_cur <= '0;
    end else if (sts_rdy) begin
      if (sts_trg) begin
        ptr_cur <= cfg.off;
      end else if (sts_aen) begin
        ptr_cur <= ptr_sub[CWP+1] ? ptr_nxt[CWP-1:0] : ptr_sub[CWP-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // valid and last pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_vld   <= 1'b0;
      sts_ren   <= 1'b0;
      sts_lst   <= 1'b0;
      smp_valid <= 1'b0;
      out_lst   <= 1'b0;
    end else if (sts_rdy) begin
      sts_vld   <= sts_run;
      sts_ren   <= sts_aen;
      sts_lst   <= sts_rpt & end_bnm;
      smp_valid <= sts_vld;
      out_lst   <= sts_lst;
    end
  end

  // sample straight from the table register
  assign smp = '{dat: rdata, lst: out_lst};

  // events
  assign evn = '{per: sts_rpt & sts_rdy, lst: sts_lst & sts_rdy, run: sts_run};

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // pointer inside the table
  a_ptr_range: assert property (@(posedge sto) disable iff (ctl_rst)
    sts_run |-> ({1'b0, ptr_cur} < ptr_mod));

  // stalled beat holds
  a_smp_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    smp_valid && !smp_ready |=> smp_valid && $stable(smp));

  // table is only written while idle
  a_wr_idle: assert property (@(posedge sto) disable iff (ctl_rst)
    wen |-> !sts_run && !smp_valid);

endmodule

/* asg_channel/asg_table.sv */
`timescale 1ns/1ps

// sample table for one channel
// write port from outside, registered read port toward playback

module asg_table import asg_cfg_pkg::*; #(
  parameter type dt = logic
) (
  input  logic           sto,
  // write side
  input  logic           wen,
  input  logic [CWM-1:0] waddr,
  input  dt              wdata,
  // read side
  input  logic           ren,
  input  logic [CWM-1:0] raddr,
  output dt              rdata
);

  // table storage
  dt mem [0:2**CWM-1];

  // write on strobe
  always_ff @(posedge sto) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  // read only while enabled
  // a stalled pipeline keeps rdata frozen
  always_ff @(posedge sto) begin
    if (ren) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* common/asg_cfg_pkg.sv */
// channel configuration, table write and event types

package asg_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // pointer magnitude bits, 64 entry table
  localparam int unsigned CWM = 6;
  // pointer fraction bits
  localparam int unsigned CWF = 4;
  // full fixed point pointer width
  localparam int unsigned CWP = CWM + CWF;
  // burst length counter width
  localparam int unsigned CWL = 16;
  // repetition counter width
  localparam int unsigned CWN = 8;
  // channel count and select width
  localparam int unsigned NCH = 2;
  localparam int unsigned CHW = $clog2(NCH);

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // per channel playback setup
  typedef struct packed {
    logic [CWM-1:0] siz;  // table size minus one, in entries
    logic [CWP-1:0] ste;  // step minus one, fixed point
    logic [CWP-1:0] off;  // start offset, fixed point
    logic           ben;  // burst enable
    logic           inf;  // infinite repetitions
    logic [CWL-1:0] bdl;  // burst data length minus one
    logic [CWL-1:0] bln;  // burst period length minus one
    logic [CWN-1:0] bnm;  // repetitions minus one
  } chn_cfg_t;

  // table write strobe, one channel at a time
  typedef struct packed {
    logic [CHW-1:0]                 chn;
    logic [CWM-1:0]                 adr;
    logic [asg_stream_pkg::DW-1:0]  dat;
    logic                           wen;
  } tbl_wr_t;

  // channel events
  typedef struct packed {
    logic per;  // new burst period
    logic lst;  // final sample issued
    logic run;  // playback active
  } chn_evn_t;

endpackage

/* common/asg_stream_pkg.sv */
// sample stream types and saturation limits

package asg_stream_pkg;

  // sample width
  localparam int unsigned DW = 14;
  // sum width, one spare bit for two channels
  localparam int unsigned DWS = DW + 1;

  // signed sample word
  typedef logic signed [DW-1:0] smp_dat_t;

  // single channel stream beat
  typedef struct packed {
    smp_dat_t dat;
    logic     lst;
  } chn_smp_t;

  // mixed DAC stream beat
  typedef struct packed {
    smp_dat_t dat;
    // set if any enabled channel ended
    logic     lst;
  } dac_smp_t;

  ////////////////////////////////////////////////////////////
  // saturation limits
  ////////////////////////////////////////////////////////////

  // +8191
  localparam smp_dat_t SMP_MAX = {1'b0, {(DW-1){1'b1}}};
  // -8192
  localparam smp_dat_t SMP_MIN = {1'b1, {(DW-1){1'b0}}};

endpackage

/* list.f */
common/asg_stream_pkg.sv
common/asg_cfg_pkg.sv
asg_channel/asg_table.sv
asg_channel/asg_channel.sv
rtl/stream_reg.sv
rtl/asg_mixer.sv
rtl/asg_top.sv
testbench/asg_tb.sv

/* rtl/asg_mixer.sv */
`timescale 1ns/1ps

// joins the channel streams into one DAC stream
// saturating sum, merged last flag

module asg_mixer import asg_cfg_pkg::*, asg_stream_pkg::*; (
  input  logic           sto,
  input  logic           ctl_rst,
  input  logic [NCH-1:0] cfg_men,
  // channel streams
  input  logic [NCH-1:0] smp_valid,
  input  chn_smp_t       smp [NCH],
  output logic [NCH-1:0] smp_ready,
  // DAC stream
  output logic           dac_valid,
  output dac_smp_t       dac,
  input  logic           dac_ready
);

  logic                  sum_valid;
  logic                  sum_ready;
  logic signed [DWS-1:0] sum;
  logic                  sum_lst;
  dac_smp_t              sum_dat;

  ////////////////////////////////////////////////////////////
  // join
  ////////////////////////////////////////////////////////////

  // wait on every enabled channel, nothing if none enabled
  assign sum_valid = (|cfg_men) & (&(smp_valid | ~cfg_men));

  // enabled channels move together
  // disabled channels drain freely
  assign smp_ready = ~cfg_men | {NCH{sum_valid & sum_ready}};

  ////////////////////////////////////////////////////////////
  // sum and saturate
  ////////////////////////////////////////////////////////////

  always_comb begin
    sum     = '0;
    sum_lst = 1'b0;
    for (int i = 0; i < NCH; i++) begin
      if (cfg_men[i]) begin
        // disabled channel adds zero
        sum     = sum + DWS'(smp[i].dat);
        sum_lst = sum_lst | smp[i].lst;
      end
    end
  end

  always_comb begin
    if (sum > SMP_MAX) begin
      sum_dat.dat = SMP_MAX;
    end else if (sum < SMP_MIN) begin
      sum_dat.dat = SMP_MIN;
    end else begin
      sum_dat.dat = sum[DW-1:0];
    end
    sum_dat.lst = sum_lst;
  end

  // output slice
  stream_reg #(.pt(dac_smp_t)) u_slc (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .in_valid  (sum_valid),
    .in_dat    (sum_dat),
    .in_ready  (sum_ready),
    .out_valid (dac_valid),
    .out_dat   (dac),
    .out_ready (dac_ready)
  );

  // no channel enabled and slice free last cycle, so nothing comes out
  a_no_chn: assert property (@(posedge sto) disable iff (ctl_rst)
    $past(cfg_men == '0) && $past(!dac_valid || dac_ready) |-> !dac_valid);

endmodule

/* rtl/asg_top.sv */
`timescale 1ns/1ps

// two channel generator for one DAC
// channels feed the mixer, mixer feeds the DAC stream

module asg_top import asg_cfg_pkg::*, asg_stream_pkg::*; (
  input  logic           sto,
  input  logic           ctl_rst,
  // table writes
  input  tbl_wr_t        tbl_wr,
  // per channel trigger and setup
  input  logic [NCH-1:0] trg,
  input  chn_cfg_t       cfg [NCH],
  input  logic [NCH-1:0] cfg_men,
  // DAC stream
  output logic           dac_valid,
  output dac_smp_t       dac,
  input  logic           dac_ready,
  // events
  output chn_evn_t       evn [NCH]
);

  // channel streams
  logic [NCH-1:0] smp_valid;
  logic [NCH-1:0] smp_ready;
  chn_smp_t       smp [NCH];

  ////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NCH; i++) begin : g_chn
    // write strobe decoded by channel select
    asg_channel u_chn (
      .sto       (sto),
      .ctl_rst   (ctl_rst),
      .wen       (tbl_wr.wen && (tbl_wr.chn == CHW'(i))),
      .waddr     (tbl_wr.adr),
      .wdata     (tbl_wr.dat),
      .trg       (trg[i]),
      .cfg       (cfg[i]),
      .smp_ready (smp_ready[i]),
      .smp_valid (smp_valid[i]),
      .smp       (smp[i]),
      .evn       (evn[i]),
      .sts_bln   (),
      .sts_bnm   ()
    );
  end

  ////////////////////////////////////////////////////////////
  // mixer
  ////////////////////////////////////////////////////////////

  asg_mixer u_mix (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .cfg_men   (cfg_men),
    .smp_valid (smp_valid),
    .smp       (smp),
    .smp_ready (smp_ready),
    .dac_valid (dac_valid),
    .dac       (dac),
    .dac_ready (dac_ready)
  );

endmodule

/* rtl/stream_reg.sv */
`timescale 1ns/1ps

// single entry valid/ready slice
// full throughput, payload type from parameter

module stream_reg #(
  parameter type pt = logic
) (
  input  logic sto,
  input  logic ctl_rst,
  // upstream
  input  logic in_valid,
  input  pt    in_dat,
  output logic in_ready,
  // downstream
  output logic out_valid,
  output pt    out_dat,
  input  logic out_ready
);

  // take new data when empty or being drained
  assign in_ready = out_ready | ~out_valid;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload
  always_ff @(posedge sto) begin
    if (in_valid && in_ready) begin
      out_dat <= in_dat;
    end
  end

  // held under stall
  a_out_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    out_valid && !out_ready |=> out_valid && $stable(out_dat));

endmodule

/* testbench/asg_tb.sv */
`timescale 1ns/1ps

// testbench for the two channel waveform generator
// vectors come from a file
// inputs change on the falling edge and beats are taken on the rising edge

module asg_tb import asg_cfg_pkg::*, asg_stream_pkg::*; ();

  // DUT side
  logic           sto;
  logic           ctl_rst;
  tbl_wr_t        tbl_wr;
  logic [NCH-1:0] trg;
  chn_cfg_t       cfg [NCH];
  logic [NCH-1:0] cfg_men;
  logic           dac_valid;
  dac_smp_t       dac;
  logic           dac_ready;
  chn_evn_t       evn [NCH];

  // run state
  int    cyc = 0;
  int    lim = 0;
  int    n_mis = 0;
  int    n_lost = 0;
  int    n_oth = 0;
  int    rdy_mode = 0;
  string tname = "none";
  // event pulses summed over both channels
  int    cnt_per = 0;
  int    cnt_elst = 0;
  // expected beats of the current test
  logic [DW-1:0] exp_dat [$];
  logic          exp_lst [$];

  asg_top dut (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .tbl_wr    (tbl_wr),
    .trg       (trg),
    .cfg       (cfg),
    .cfg_men   (cfg_men),
    .dac_valid (dac_valid),
    .dac       (dac),
    .dac_ready (dac_ready),
    .evn       (evn)
  );

  // 100 ns clock
  initial begin
    sto = 1'b0;
    forever #50 sto = ~sto;
  end

  // cycle counter against a limit set once the vectors are counted
  initial begin
    while (lim == 0 || cyc < lim) begin
      @(posedge sto);
      cyc++;
    end
    $display("timeout: run stopped after %0d cycles", cyc);
    $display("errors: %0d mismatch, %0d missing, %0d other", n_mis, n_lost, n_oth + 1);
    $display("TESTS FAILED");
    $finish;
  end

  // period and last pulses of the channels
  always @(posedge sto) begin
    for (int i = 0; i < NCH; i++) begin
      if (evn[i].per === 1'b1) begin
        cnt_per++;
      end
      if (evn[i].lst === 1'b1) begin
        cnt_elst++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // step to the falling edge and set ready for the next rising edge
  task automatic next_cycle();
    @(negedge sto);
    if (rdy_mode == 0) begin
      dac_ready = 1'b1;
    end else begin
      dac_ready = ($urandom % 2) == 1;
    end
  endtask

  // hold reset for 8 cycles and expect idle outputs
  task automatic apply_reset();
    ctl_rst = 1'b1;
    trg     = '0;
    repeat (8) next_cycle();
    if (dac_valid) begin
      $display("%s: dac_valid still high under reset", tname);
      n_oth++;
    end
    if (evn[0].run || evn[1].run) begin
      $display("%s: channel run flag still high under reset", tname);
      n_oth++;
    end
    ctl_rst = 1'b0;
  endtask

  task automatic write_word(input int ch, input int adr, input int v);
    next_cycle();
    tbl_wr = '{chn: CHW'(ch), adr: CWM'(adr), dat: DW'(v), wen: 1'b1};
    next_cycle();
    tbl_wr.wen = 1'b0;
  endtask

  // trigger and collect beats in order, then check quiet or reset
  task automatic play_and_check(input int trg_val, input int retrig_at, input int quiet);
    int got;
    int wait_cyc;
    int n_exp;
    int exp_per;
    int exp_elst;
    int chk_per;
    got      = 0;
    wait_cyc = 0;
    n_exp    = exp_dat.size();
    exp_per  = 0;
    exp_elst = 0;
    chk_per  = 1;
    // one last pulse for each final burst beat
    foreach (exp_lst[i]) begin
      if (exp_lst[i]) begin
        exp_elst++;
      end
    end
    // one period pulse per burst period of a triggered channel
    for (int i = 0; i < NCH; i++) begin
      if (trg_val[i] && cfg[i].ben) begin
        if (cfg[i].inf) begin
          chk_per = 0;
        end
        exp_per += int'(cfg[i].bnm) + 1;
      end
    end
    next_cycle();
    trg      = NCH'(trg_val);
    cnt_per  = 0;
    cnt_elst = 0;
    while (got < n_exp && wait_cyc < n_exp * 4 + 50) begin
      next_cycle();
      // beat is taken at the coming rising edge
      if (dac_valid && dac_ready) begin
        if (dac.dat !== exp_dat[got] || dac.lst !== exp_lst[got]) begin
          $display("FAIL %s beat %0d: expected %h/%b, actual %h/%b",
                   tname, got, exp_dat[got], exp_lst[got], dac.dat, dac.lst);
          n_mis++;
        end
        // triggered channels run while the first beat leaves
        if (got == 0) begin
          for (int i = 0; i < NCH; i++) begin
            if (trg_val[i] && evn[i].run !== 1'b1) begin
              $display("FAIL %s evn run ch %0d: expected 1, actual %b",
                       tname, i, evn[i].run);
              n_mis++;
            end
          end
        end
        got++;
      end
      // retrigger while running is ignored by the channel
      trg = (retrig_at != 0 && got == retrig_at) ? NCH'(trg_val) : '0;
      wait_cyc++;
    end
    trg = '0;
    if (got < n_exp) begin
      $display("%s: missing output, only %0d of %0d samples arrived", tname, got, n_exp);
      n_lost++;
    end
    if (chk_per != 0 && cnt_per != exp_per) begin
      $display("FAIL %s evn per pulses: expected %0d, actual %0d", tname, exp_per, cnt_per);
      n_mis++;
    end
    if (cnt_elst != exp_elst) begin
      $display("FAIL %s evn lst pulses: expected %0d, actual %0d", tname, exp_elst, cnt_elst);
      n_mis++;
    end
    if (quiet != 0) begin
      // finished burst stays silent
      repeat (20) begin
        next_cycle();
        if (dac_valid) begin
          $display("%s: dac_valid seen after the final burst sample", tname);
          n_oth++;
        end
      end
    end else begin
      apply_reset();
    end
    exp_dat.delete();
    exp_lst.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    r;
    int    ch;
    int    n;
    int    v;
    int    l;
    int    total;
    int    f [8];
    string tok;
    string line;
    ctl_rst   = 1'b1;
    tbl_wr    = '0;
    trg       = '0;
    cfg_men   = '0;
    cfg[0]    = '0;
    cfg[1]    = '0;
    dac_ready = 1'b1;
    total     = 0;
    r = $urandom(6);
    apply_reset();
    // first pass counts expected beats
    fd = $fopen("testbench/asg_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file");
      n_oth++;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok == "#") begin
          r = $fgets(line, fd);
        end else if (tok == "E") begin
          r = $fscanf(fd, "%h", n);
          total += n;
        end
      end
      $fclose(fd);
      lim = total * 4 + 200;
      fd = $fopen("testbench/asg_vectors.txt", "r");
    end
    // second pass runs the tests
    while (fd != 0 && $fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        r = $fgets(line, fd);
      end else if (tok == "T") begin
        r = $fscanf(fd, "%s", tname);
      end else if (tok == "W") begin
        r = $fscanf(fd, "%h %h", ch, n);
        for (int i = 0; i < n; i++) begin
          r = $fscanf(fd, "%h", v);
          write_word(ch, i, v);
        end
      end else if (tok == "C") begin
        r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                    ch, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
        cfg[ch].siz = CWM'(f[0]);
        cfg[ch].ste = CWP'(f[1]);
        cfg[ch].off = CWP'(f[2]);
        cfg[ch].ben = f[3][0];
        cfg[ch].inf = f[4][0];
        cfg[ch].bdl = CWL'(f[5]);
        cfg[ch].bln = CWL'(f[6]);
        cfg[ch].bnm = CWN'(f[7]);
      end else if (tok == "M") begin
        r = $fscanf(fd, "%h", v);
        cfg_men = NCH'(v);
      end else if (tok == "R") begin
        r = $fscanf(fd, "%h", rdy_mode);
      end else if (tok == "E") begin
        r = $fscanf(fd, "%h", n);
        for (int i = 0; i < n; i++) begin
          r = $fscanf(fd, "%h %h", v, l);
          exp_dat.push_back(DW'(v));
          exp_lst.push_back(l[0]);
        end
      end else if (tok == "X") begin
        r = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
        play_and_check(f[0], f[1], f[2]);
      end else begin
        $display("unknown vector token %s", tok);
        n_oth++;
      end
    end
    $display("errors: %0d mismatch, %0d missing, %0d other", n_mis, n_lost, n_oth);
    if (n_mis + n_lost + n_oth == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/asg_vectors.txt */
# T name | W chn count words from address 0 | C chn siz ste off ben inf bdl bln bnm
# M mixer enable | R ready 0 high 1 random | E count then dat lst pairs | X trg retrig quiet
T periodic
W 0 4 0011 0022 0033 0044
C 0 03 00f 000 0 0 0000 0000 00
M 1
R 0
E 0a 0011 0 0022 0 0033 0 0044 0 0011 0 0022 0 0033 0 0044 0 0011 0 0022 0
X 1 0 0
T fraction
C 0 03 017 008 0 0 0000 0000 00
R 0
E 0a 0011 0 0033 0 0044 0 0022 0 0033 0 0011 0 0022 0 0044 0 0011 0 0033 0
X 1 0 0
T burst
C 0 03 00f 000 1 0 0001 0003 01
R 0
E 08 0011 0 0022 0 0022 0 0022 0 0011 0 0022 0 0022 0 0022 1
X 1 0 1
E 08 0011 0 0022 0 0022 0 0022 0 0011 0 0022 0 0022 0 0022 1
X 1 0 0
T stall
C 0 03 00f 000 0 0 0000 0000 00
R 1
E 10 0011 0 0022 0 0033 0 0044 0 0011 0 0022 0 0033 0 0044 0
0011 0 0022 0 0033 0 0044 0 0011 0 0022 0 0033 0 0044 0
X 1 0 0
T retrigger
R 0
E 08 0011 0 0022 0 0033 0 0044 0 0011 0 0022 0 0033 0 0044 0
X 1 3 0
T mix
W 0 4 1fff 2000 1000 0005
W 1 4 1fff 2000 1000 3ffb
C 1 03 00f 000 0 0 0000 0000 00
M 3
R 0
E 08 1fff 0 2000 0 1fff 0 0000 0 1fff 0 2000 0 1fff 0 0000 0
X 3 0 0
